// ==== Makefile ====
# Verilator flow for core_top and its testbench
# make lint   checks the RTL
# make sim    builds and runs the testbench, fails unless it passes
# make clean  removes the build folder

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module core_top -f src.f

sim:
	verilator --binary --timing --assert --top-module tb_core_top -f src.f -o sim_tb
	out=$$(./obj_dir/sim_tb); echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== bridge_regs.sv ====
// Settings register block on the host bridge.
// Stores the variant, overscan, border and extended-save bits, answers
// bridge reads combinationally and decodes writes into loader regions.

`timescale 1ns/1ns

module bridge_regs (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,
  input  logic [core_pkg::bridge_w-1:0]       bridge_addr,
  input  logic                                bridge_rd,
  input  logic                                bridge_wr,
  input  logic [core_pkg::bridge_w-1:0]       bridge_wr_data,
  output logic [core_pkg::bridge_w-1:0]       bridge_rd_data,
  output logic [core_pkg::num_regions-1:0]    region_wr,
  output logic                                variant_sel,
  output logic                                overscan_en,
  output logic                                border_en
);

  import core_pkg::*;

  logic ext_save_en;
  logic [region_nib_w-1:0] addr_nib;

  assign addr_nib = bridge_addr[bridge_w-1 -: region_nib_w];

  ////////////////////////////////////////
  // settings registers

  // only bit 0 of the write word matters
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      variant_sel <= 1'b0;
      overscan_en <= 1'b0;
      border_en   <= 1'b0;
      ext_save_en <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_variant:  variant_sel <= bridge_wr_data[0];
        addr_overscan: overscan_en <= bridge_wr_data[0];
        addr_border:   border_en   <= bridge_wr_data[0];
        addr_ext_save: ext_save_en <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // read mux

  always_comb begin
    bridge_rd_data = '0;
    case (bridge_addr)
      addr_variant:   bridge_rd_data[0] = variant_sel;
      addr_overscan:  bridge_rd_data[0] = overscan_en;
      addr_border:    bridge_rd_data[0] = border_en;
      addr_ext_save:  bridge_rd_data[0] = ext_save_en;
      addr_save_size: bridge_rd_data = ext_save_en ? save_size_ext : save_size_small;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // region write decode

  // one strobe per loader channel, same cycle as bridge_wr
  always_comb begin
    for (int i = 0; i < num_regions; i++) begin
      region_wr[i] = bridge_wr && (addr_nib == region_base + region_nib_w'(i));
    end
  end

  // host never issues a read and a write in the same cycle
  a_rd_wr_excl : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    !(bridge_rd && bridge_wr)
  );

endmodule

// ==== core_pkg.sv ====
// Shared definitions for the bridge-facing part of the core top level.
// Holds the host bridge address map, datapath widths, loader region codes
// and the video formatter line state. Modules import it inside their body.

package core_pkg;

  ////////////////////////////////////////
  // widths

  localparam int unsigned bridge_w    = 32;
  localparam int unsigned half_w      = 16;
  localparam int unsigned load_addr_w = 24;
  localparam int unsigned rgb_w       = 24;
  localparam int unsigned div_w       = 2;

  ////////////////////////////////////////
  // loader regions

  // top address nibble selects the region
  localparam int unsigned region_nib_w = 4;
  localparam int unsigned num_regions  = 2;
  // channel i answers to nibble region_base + i
  localparam logic [region_nib_w-1:0] region_base = 4'h1;

  ////////////////////////////////////////
  // settings address map

  localparam logic [bridge_w-1:0] addr_variant   = 32'h0000_0004;
  localparam logic [bridge_w-1:0] addr_overscan  = 32'h0000_0100;
  localparam logic [bridge_w-1:0] addr_border    = 32'h0000_0104;
  localparam logic [bridge_w-1:0] addr_ext_save  = 32'h0000_0200;
  // read only
  localparam logic [bridge_w-1:0] addr_save_size = 32'h0000_0208;

  // save size in bytes, normal and extended
  localparam logic [bridge_w-1:0] save_size_small = 32'h0000_0800;
  localparam logic [bridge_w-1:0] save_size_ext   = 32'h0002_0000;

  ////////////////////////////////////////
  // video formatter

  // hsync rising edge to output pulse, in cycles
  localparam int unsigned hs_delay_cycles = 3;
  localparam int unsigned hs_cnt_w        = $clog2(hs_delay_cycles);
  // slot code position in the end-of-line word
  localparam int unsigned eol_slot_lsb    = 13;

  typedef enum logic [1:0] {
    line_idle,
    line_active,
    line_end
  } fmt_state_e;

endpackage

// ==== core_top.sv ====
// Bridge-facing top level of the handheld core, all in the clk_74a domain.
// Wires the settings block, one loader channel per memory region and the
// video formatter. Settings bits leave as status outputs.

`timescale 1ns/1ns

module core_top (
  input  logic                                                   clk_74a,
  input  logic                                                   pll_core_locked,

  // host bridge
  input  logic [core_pkg::bridge_w-1:0]                          bridge_addr,
  input  logic                                                   bridge_rd,
  output logic [core_pkg::bridge_w-1:0]                          bridge_rd_data,
  input  logic                                                   bridge_wr,
  input  logic [core_pkg::bridge_w-1:0]                          bridge_wr_data,

  // core video
  input  logic                                                   core_hblank,
  input  logic                                                   core_vblank,
  input  logic                                                   core_hsync,
  input  logic                                                   core_vsync,
  input  logic [core_pkg::rgb_w-1:0]                             core_rgb,
  input  logic [core_pkg::div_w-1:0]                             dotclock_divider,

  // memory write ports, one per region
  output logic [core_pkg::num_regions-1:0]                       mem_wr,
  output logic [core_pkg::num_regions-1:0][core_pkg::load_addr_w-1:0] mem_addr,
  output logic [core_pkg::num_regions-1:0][core_pkg::half_w-1:0] mem_data,

  // scaler video
  output logic                                                   video_de,
  output logic                                                   video_hs,
  output logic                                                   video_vs,
  output logic [core_pkg::rgb_w-1:0]                             video_rgb,

  // settings status
  output logic                                                   variant_sel,
  output logic                                                   overscan_en,
  output logic                                                   border_en
);

  import core_pkg::*;

  logic [num_regions-1:0] region_wr;

  bridge_regs u_regs (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .region_wr       (region_wr),
    .variant_sel     (variant_sel),
    .overscan_en     (overscan_en),
    .border_en       (border_en)
  );

  ////////////////////////////////////////
  // loaders, cartridge then save

  for (genvar i = 0; i < num_regions; i++) begin : g_loader
    data_loader u_loader (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked),
      .region_wr       (region_wr[i]),
      .bridge_addr     (bridge_addr[load_addr_w-1:0]),
      .bridge_wr_data  (bridge_wr_data),
      .mem_wr          (mem_wr[i]),
      .mem_addr        (mem_addr[i]),
      .mem_data        (mem_data[i])
    );
  end

  video_formatter u_video (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .core_hblank      (core_hblank),
    .core_vblank      (core_vblank),
    .core_hsync       (core_hsync),
    .core_vsync       (core_vsync),
    .core_rgb         (core_rgb),
    .dotclock_divider (dotclock_divider),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs),
    .video_rgb        (video_rgb)
  );

endmodule

// ==== data_loader.sv ====
// One loader channel between the host bridge and a 16-bit memory port.
// A 32-bit bridge write becomes two write strobes on consecutive cycles,
// upper half first at the byte address, lower half at address plus 2.
// Instantiated once per region by the top level.

`timescale 1ns/1ns

module data_loader (
  input  logic                              clk_74a,
  input  logic                              pll_core_locked,
  input  logic                              region_wr,
  input  logic [core_pkg::load_addr_w-1:0]  bridge_addr,
  input  logic [core_pkg::bridge_w-1:0]     bridge_wr_data,
  output logic                              mem_wr,
  output logic [core_pkg::load_addr_w-1:0]  mem_addr,
  output logic [core_pkg::half_w-1:0]       mem_data
);

  import core_pkg::*;

  // second half held for the following cycle
  logic                   lo_pend;
  logic [load_addr_w-1:0] lo_addr;
  logic [half_w-1:0]      lo_data;

  ////////////////////////////////////////
  // strobe and pending flag

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      mem_wr  <= 1'b0;
      lo_pend <= 1'b0;
    end else begin
      mem_wr  <= region_wr || lo_pend;
      lo_pend <= region_wr;
    end
  end

  ////////////////////////////////////////
  // payload

  // region_wr and lo_pend are never high together, since the host
  // spaces its writes to one region by at least 2 cycles
  always_ff @(posedge clk_74a) begin
    if (region_wr) begin
      mem_addr <= bridge_addr;
      mem_data <= bridge_wr_data[bridge_w-1 -: half_w];
      lo_addr  <= bridge_addr + load_addr_w'(2);
      lo_data  <= bridge_wr_data[half_w-1:0];
    end else if (lo_pend) begin
      mem_addr <= lo_addr;
      mem_data <= lo_data;
    end
  end

  // the pipeline has one output slot per cycle, so back-to-back
  // writes to a region would lose a half word
  a_wr_spacing : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    region_wr |=> !region_wr
  );

endmodule

// ==== src.f ====
core_pkg.sv
bridge_regs.sv
data_loader.sv
video_formatter.sv
core_top.sv
tb_core_top.sv

// ==== tb_core_top.sv ====
// Directed testbench for the bridge-facing core top level.
// Covers the settings registers, both loader channels, video line
// formatting and the sync pulses. Random data comes from a fixed seed.

`timescale 1ns/1ns

module tb_core_top;

  import core_pkg::*;

  // register map values as the bridge documentation gives them
  localparam logic [31:0] size_small_exp = 32'h0000_0800;
  localparam logic [31:0] size_ext_exp   = 32'h0002_0000;
  localparam int          eol_bit        = 13;
  localparam int          drain_limit    = 8;

  logic                                    clk_74a;
  logic                                    pll_core_locked;
  logic [bridge_w-1:0]                     bridge_addr;
  logic                                    bridge_rd;
  logic [bridge_w-1:0]                     bridge_rd_data;
  logic                                    bridge_wr;
  logic [bridge_w-1:0]                     bridge_wr_data;
  logic                                    core_hblank;
  logic                                    core_vblank;
  logic                                    core_hsync;
  logic                                    core_vsync;
  logic [rgb_w-1:0]                        core_rgb;
  logic [div_w-1:0]                        dotclock_divider;
  logic [num_regions-1:0]                  mem_wr;
  logic [num_regions-1:0][load_addr_w-1:0] mem_addr;
  logic [num_regions-1:0][half_w-1:0]      mem_data;
  logic                                    video_de;
  logic                                    video_hs;
  logic                                    video_vs;
  logic [rgb_w-1:0]                        video_rgb;
  logic                                    variant_sel;
  logic                                    overscan_en;
  logic                                    border_en;

  // expected loader half-word writes, oldest first
  logic [load_addr_w-1:0] exp_addr_q [$];
  logic [half_w-1:0]      exp_data_q [$];

  core_top u_dut (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bridge_addr      (bridge_addr),
    .bridge_rd        (bridge_rd),
    .bridge_rd_data   (bridge_rd_data),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .core_hblank      (core_hblank),
    .core_vblank      (core_vblank),
    .core_hsync       (core_hsync),
    .core_vsync       (core_vsync),
    .core_rgb         (core_rgb),
    .dotclock_divider (dotclock_divider),
    .mem_wr           (mem_wr),
    .mem_addr         (mem_addr),
    .mem_data         (mem_data),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs),
    .video_rgb        (video_rgb),
    .variant_sel      (variant_sel),
    .overscan_en      (overscan_en),
    .border_en        (border_en)
  );

  initial begin
    clk_74a = 1'b0;
    forever begin
      #5 clk_74a = ~clk_74a;
    end
  end

  ////////////////////////////////////////
  // helpers

  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("FAIL at %0t ns: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic give_up(input string what);
    $display("timed out waiting for %s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic bridge_write(input logic [bridge_w-1:0] addr,
                              input logic [bridge_w-1:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    tick();
    bridge_wr      = 1'b0;
  endtask

  // read data is combinational, sampled mid-cycle
  task automatic bridge_read_expect(input logic [bridge_w-1:0] addr,
                                    input logic [bridge_w-1:0] exp);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    #1;
    expect_true(bridge_rd_data == exp,
      $sformatf("read of 0x%08h gave 0x%08h, expected 0x%08h", addr, bridge_rd_data, exp));
    tick();
    bridge_rd = 1'b0;
  endtask

  // slot code is min(divider, 2) at bit 13, all else zero
  function automatic logic [rgb_w-1:0] eol_word(input logic [div_w-1:0] div);
    logic [rgb_w-1:0] w;
    logic [1:0]       code;
    code = (div > 2'd2) ? 2'd2 : div;
    w = '0;
    w[eol_bit +: 2] = code;
    return w;
  endfunction

  ////////////////////////////////////////
  // settings registers

  // bit 0 carries the setting, upper bits are random noise
  task automatic set_setting(input logic [bridge_w-1:0] addr, input logic value);
    logic [bridge_w-1:0] word;
    logic                status;
    logic                has_status;
    word       = $urandom;
    word[0]    = value;
    status     = 1'b0;
    has_status = 1'b1;
    bridge_write(addr, word);
    bridge_read_expect(addr, {31'b0, value});
    case (addr)
      addr_variant:  status = variant_sel;
      addr_overscan: status = overscan_en;
      addr_border:   status = border_en;
      // extended save has no status output
      default:       has_status = 1'b0;
    endcase
    if (has_status) begin
      expect_true(status == value,
        $sformatf("status output for 0x%08h is %0b, expected %0b", addr, status, value));
    end
    if (addr == addr_ext_save) begin
      bridge_read_expect(addr_save_size, value ? size_ext_exp : size_small_exp);
    end
  endtask

  task automatic settings_readback();
    logic [bridge_w-1:0] map [4];
    map = '{addr_variant, addr_overscan, addr_border, addr_ext_save};
    foreach (map[i]) begin
      bridge_read_expect(map[i], '0);
    end
    bridge_read_expect(addr_save_size, size_small_exp);
    foreach (map[i]) begin
      set_setting(map[i], 1'b1);
    end
    foreach (map[i]) begin
      set_setting(map[i], 1'b0);
    end
    // a write to a hole lands nowhere
    bridge_write(32'h0000_0108, 32'hFFFF_FFFF);
    foreach (map[i]) begin
      bridge_read_expect(map[i], '0);
    end
    bridge_read_expect(32'h0000_0000, '0);
    bridge_read_expect(32'h0000_0008, '0);
    bridge_read_expect(32'h0000_0108, '0);
    bridge_read_expect(32'h0000_020C, '0);
    bridge_read_expect(32'h1000_0000, '0);
  endtask

  ////////////////////////////////////////
  // loader channels

  // one cycle of the loader ports against the expected queue
  task automatic check_mem_port(input int ch);
    logic [num_regions-1:0] others;
    logic [load_addr_w-1:0] a;
    logic [half_w-1:0]      d;
    others     = '1;
    others[ch] = 1'b0;
    expect_true((mem_wr & others) == '0, "mem_wr strobe on an idle channel");
    if (exp_addr_q.size() == 0) begin
      expect_true(mem_wr[ch] == 1'b0, $sformatf("unexpected mem_wr on channel %0d", ch));
    end else begin
      a = exp_addr_q.pop_front();
      d = exp_data_q.pop_front();
      expect_true(mem_wr[ch] == 1'b1, $sformatf("missing mem_wr on channel %0d", ch));
      expect_true(mem_addr[ch] == a && mem_data[ch] == d,
        $sformatf("channel %0d wrote 0x%04h at 0x%06h, expected 0x%04h at 0x%06h",
                  ch, mem_data[ch], mem_addr[ch], d, a));
    end
  endtask

  // n random words to the region of channel ch, one every gap cycles
  task automatic loader_stream(input int ch, input int n_words, input int gap);
    logic [bridge_w-1:0]    r;
    logic [bridge_w-1:0]    word;
    logic [load_addr_w-1:0] off;
    logic [3:0]             nib;
    int                     sent;
    int                     k;
    int                     waited;
    nib    = 4'(ch + 1);
    sent   = 0;
    k      = 0;
    waited = 0;
    while (sent < n_words) begin
      if (k % gap == 0) begin
        r    = $urandom;
        word = $urandom;
        off  = {r[load_addr_w-1:1], 1'b0};
        bridge_addr    = {nib, 4'h0, off};
        bridge_wr_data = word;
        bridge_wr      = 1'b1;
        // upper half next cycle, lower half at +2 the cycle after
        exp_addr_q.push_back(off);
        exp_data_q.push_back(word[31:16]);
        exp_addr_q.push_back(off + 24'd2);
        exp_data_q.push_back(word[15:0]);
        sent++;
      end else begin
        bridge_wr = 1'b0;
      end
      tick();
      k++;
      check_mem_port(ch);
    end
    bridge_wr = 1'b0;
    while (exp_addr_q.size() != 0 && waited < drain_limit) begin
      tick();
      waited++;
      check_mem_port(ch);
    end
    if (exp_addr_q.size() != 0) begin
      give_up($sformatf("loader channel %0d to finish", ch));
    end else begin
      tick();
      check_mem_port(ch);
    end
  endtask

  ////////////////////////////////////////
  // video formatter

  // blank, n_active random pixels, then blank again
  task automatic video_line(input logic [div_w-1:0] div, input int n_active);
    logic [bridge_w-1:0] r;
    logic [rgb_w-1:0]    exp_rgb;
    logic                check_rgb;
    logic                last_de;
    logic                de;
    int                  len;
    len              = n_active + 5;
    last_de          = 1'b0;
    check_rgb        = 1'b0;
    exp_rgb          = '0;
    dotclock_divider = div;
    core_vblank      = 1'b0;
    for (int k = 0; k <= len; k++) begin
      de          = (k >= 2) && (k < 2 + n_active);
      r           = $urandom;
      core_hblank = !de;
      core_rgb    = r[rgb_w-1:0];
      if (de) begin
        exp_rgb   = r[rgb_w-1:0];
        check_rgb = 1'b1;
      end else if (last_de) begin
        exp_rgb   = eol_word(div);
        check_rgb = 1'b1;
      end else begin
        check_rgb = 1'b0;
      end
      last_de = de;
      tick();
      expect_true(video_de == de, $sformatf("video_de is %0b, expected %0b", video_de, de));
      if (check_rgb) begin
        expect_true(video_rgb == exp_rgb,
          $sformatf("divider %0d: video_rgb 0x%06h, expected 0x%06h",
                    div, video_rgb, exp_rgb));
      end
    end
    core_hblank = 1'b1;
    core_vblank = 1'b1;
  endtask

  // vsync rises in cycle 2, hsync in cycle 9
  task automatic sync_pulses();
    int vs_seen;
    int hs_seen;
    vs_seen = 0;
    hs_seen = 0;
    for (int c = 0; c < 20; c++) begin
      core_vsync = (c >= 2) && (c <= 6);
      core_hsync = (c >= 9) && (c <= 11);
      tick();
      // now observing cycle c+1
      expect_true(video_vs == (c == 2),
        $sformatf("video_vs is %0b in cycle %0d", video_vs, c + 1));
      expect_true(video_hs == (c == 11),
        $sformatf("video_hs is %0b in cycle %0d", video_hs, c + 1));
      if (video_vs) begin
        vs_seen++;
      end
      if (video_hs) begin
        hs_seen++;
      end
    end
    expect_true(vs_seen == 1 && hs_seen == 1,
      $sformatf("saw %0d vsync and %0d hsync pulses, expected one each", vs_seen, hs_seen));
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    void'($urandom(86));
    pll_core_locked  = 1'b0;
    bridge_addr      = '0;
    bridge_rd        = 1'b0;
    bridge_wr        = 1'b0;
    bridge_wr_data   = '0;
    core_hblank      = 1'b1;
    core_vblank      = 1'b1;
    core_hsync       = 1'b0;
    core_vsync       = 1'b0;
    core_rgb         = '0;
    dotclock_divider = '0;
    repeat (16) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    expect_true(mem_wr == '0 && !video_de && !video_hs && !video_vs && video_rgb == '0,
                "outputs not low after reset");

    settings_readback();
    // cartridge words one at a time, save words two in flight
    loader_stream(0, 6, 3);
    loader_stream(1, 6, 2);
    for (int d = 0; d < 4; d++) begin
      video_line(div_w'(d), 4 + d);
    end
    sync_pulses();
    tick();

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== video_formatter.sv ====
// Formats raw core video for the scaler.
// Registers data enable and RGB, inserts the end-of-line slot word after
// each active line, makes a one-cycle vsync pulse and a delayed one-cycle
// hsync pulse. Every clk_74a cycle is one pixel.

`timescale 1ns/1ns

module video_formatter (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,
  input  logic                          core_hblank,
  input  logic                          core_vblank,
  input  logic                          core_hsync,
  input  logic                          core_vsync,
  input  logic [core_pkg::rgb_w-1:0]    core_rgb,
  input  logic [core_pkg::div_w-1:0]    dotclock_divider,
  output logic                          video_de,
  output logic                          video_hs,
  output logic                          video_vs,
  output logic [core_pkg::rgb_w-1:0]    video_rgb
);

  import core_pkg::*;

  fmt_state_e state;
  fmt_state_e state_nxt;

  logic              de;
  logic [1:0]        slot;
  logic [rgb_w-1:0]  slot_rgb;
  logic              hs_prev;
  logic              vs_prev;
  logic [hs_cnt_w-1:0] hs_cnt;

  assign de = !(core_hblank || core_vblank);

  // dividers 2 and 3 share slot 2
  assign slot     = (dotclock_divider > div_w'(1)) ? 2'd2 : 2'(dotclock_divider);
  assign slot_rgb = rgb_w'(slot) << eol_slot_lsb;

  ////////////////////////////////////////
  // line state

  always_comb begin
    if (de) begin
      state_nxt = line_active;
    end else if (state == line_active) begin
      state_nxt = line_end;
    end else begin
      state_nxt = line_idle;
    end
  end

  // state reflects last cycle's input, so it doubles as the output DE
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state     <= line_idle;
      video_rgb <= '0;
    end else begin
      state <= state_nxt;
      if (de) begin
        video_rgb <= core_rgb;
      end else if (state == line_active) begin
        // first blank cycle after the line
        video_rgb <= slot_rgb;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  assign video_de = (state == line_active);

  ////////////////////////////////////////
  // sync pulses

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_cnt   <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      hs_prev  <= core_hsync;
      vs_prev  <= core_vsync;
      video_vs <= core_vsync && !vs_prev;
      // countdown from the hsync rising edge to the delayed pulse
      if (core_hsync && !hs_prev) begin
        hs_cnt <= hs_cnt_w'(hs_delay_cycles - 1);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - hs_cnt_w'(1);
      end
      video_hs <= (hs_cnt == hs_cnt_w'(1));
    end
  end

  // scaler expects hsync a fixed delay after the core edge
  a_hs_delay : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(core_hsync) |-> ##hs_delay_cycles video_hs
  );

endmodule
